// ==== include/t86_settings.svh ====
`ifndef T86_SETTINGS_SVH
`define T86_SETTINGS_SVH

// Data path and state sizes.
`define T86_WORD    32
`define T86_NREGS   8
`define T86_INSTR_W 48
`define T86_HINT_W  72
`define T86_STEP_W  512

// Step word layout. The eight registers sit at the bottom, eax first.
`define T86_EIP_LSB    256
`define T86_EFLAGS_LSB 288
`define T86_INSTR_LSB  320
`define T86_HINT1_LSB  368
`define T86_HINT2_LSB  440

// Instruction fields of the fixed 48-bit encoding.
`define T86_I_OPC_LSB   0
`define T86_I_DKIND_LSB 8
`define T86_I_DSEL_LSB  10
`define T86_I_SKIND_LSB 13
`define T86_I_SSEL_LSB  15
`define T86_I_LEN_LSB   18
`define T86_I_LEN_W     4
`define T86_I_IMM_LSB   22
`define T86_I_IMM_W     26

// Hint fields.
`define T86_H_STATE_LSB 0
`define T86_H_WR_BIT    4
`define T86_H_ADDR_LSB  8
`define T86_H_DATA_LSB  40

// Eflags bits kept by the core.
`define T86_CF 0
`define T86_ZF 6
`define T86_SF 7

`endif

// ==== hw/t86_pkg.sv ====
`default_nettype none

`include "t86_settings.svh"

package t86_pkg;

  // Opcode byte of the fixed encoding.
  typedef enum logic [7:0] {
    OPC_MOV     = 8'h00,
    OPC_ADD     = 8'h01,
    OPC_SUB     = 8'h02,
    OPC_AND     = 8'h03,
    OPC_XOR     = 8'h04,
    OPC_INC     = 8'h05,
    OPC_JZ      = 8'h06,
    OPC_LOOP    = 8'h07,
    OPC_INT80   = 8'h08,
    OPC_ILLEGAL = 8'hff
  } t86_opc_e;

  typedef enum logic [1:0] {
    KIND_NONE = 2'd0,
    KIND_REG  = 2'd1,
    KIND_IMM  = 2'd2,
    KIND_MEM  = 2'd3
  } t86_kind_e;

  // Syscall progress as recorded by the tracer in hint1.
  typedef enum logic [3:0] {
    SYS_DONE  = 4'd0,
    SYS_READ  = 4'd1,
    SYS_WRITE = 4'd2
  } t86_sys_e;

  // Register numbers with a fixed role.
  localparam int unsigned REG_EAX = 0;
  localparam int unsigned REG_ECX = 1;
  localparam int unsigned REG_EDX = 2;

  // eax, ecx, edx, ebx, esp, ebp, esi, edi.
  typedef logic [`T86_NREGS-1:0][`T86_WORD-1:0] t86_regs_t;

endpackage

`default_nettype wire

// ==== hw/t86_decoded_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

interface t86_decoded_if (
  input wire i_clk
);
  import t86_pkg::*;

  t86_opc_e                opc;
  logic [`T86_I_LEN_W-1:0] instr_len;
  logic [`T86_WORD-1:0]    src_val;
  logic [`T86_WORD-1:0]    dst_val;
  t86_kind_e               dest_kind;
  logic [2:0]              dest_sel;
  // Effective address of the memory operand.
  logic [`T86_WORD-1:0]    mem_addr;
  logic                    hint_fault;

  modport decode (
    input  i_clk,
    output opc, instr_len, src_val, dst_val, dest_kind, dest_sel, mem_addr, hint_fault
  );

  modport exec (
    input i_clk, opc, instr_len, src_val, dst_val, dest_kind, dest_sel, mem_addr, hint_fault
  );

  modport wb (
    input opc, dest_kind, dest_sel, mem_addr, hint_fault
  );

endinterface

`default_nettype wire

// ==== hw/step_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

module step_decode (
  input  wire [`T86_STEP_W-1:0] i_step,
  t86_decoded_if.decode         dec,
  output t86_pkg::t86_regs_t    o_regs,
  output logic [`T86_WORD-1:0]  o_eip,
  output logic [`T86_WORD-1:0]  o_eflags
);
  import t86_pkg::*;

  logic [`T86_INSTR_W-1:0] instr;
  logic [`T86_HINT_W-1:0]  hint1;
  logic [`T86_HINT_W-1:0]  hint2;
  t86_regs_t               regs;
  logic [7:0]              opc_byte;
  t86_kind_e               src_kind;
  logic [2:0]              src_sel;
  logic [`T86_I_IMM_W-1:0] imm;
  logic [`T86_WORD-1:0]    imm_ext;
  logic [`T86_WORD-1:0]    src_reg;
  logic [`T86_WORD-1:0]    dst_reg;
  logic [3:0]              h1_state;
  logic                    h1_wr;
  logic [`T86_WORD-1:0]    h1_addr;
  logic [`T86_WORD-1:0]    h1_data;
  logic                    h2_wr;
  logic [`T86_WORD-1:0]    h2_addr;
  logic                    mem_rd;

  // Split the step into state, instruction and hints.
  assign regs  = i_step[`T86_NREGS*`T86_WORD-1:0];
  assign instr = i_step[`T86_INSTR_LSB +: `T86_INSTR_W];
  assign hint1 = i_step[`T86_HINT1_LSB +: `T86_HINT_W];
  assign hint2 = i_step[`T86_HINT2_LSB +: `T86_HINT_W];

  assign o_regs   = regs;
  assign o_eip    = i_step[`T86_EIP_LSB +: `T86_WORD];
  assign o_eflags = i_step[`T86_EFLAGS_LSB +: `T86_WORD];

  assign opc_byte = instr[`T86_I_OPC_LSB +: 8];
  assign src_kind = t86_kind_e'(instr[`T86_I_SKIND_LSB +: 2]);
  assign src_sel  = instr[`T86_I_SSEL_LSB +: 3];
  assign imm      = instr[`T86_I_IMM_LSB +: `T86_I_IMM_W];
  assign imm_ext  = {{(`T86_WORD-`T86_I_IMM_W){imm[`T86_I_IMM_W-1]}}, imm};

  assign dec.dest_kind = t86_kind_e'(instr[`T86_I_DKIND_LSB +: 2]);
  assign dec.dest_sel  = instr[`T86_I_DSEL_LSB +: 3];
  assign dec.instr_len = instr[`T86_I_LEN_LSB +: `T86_I_LEN_W];

  assign h1_state = hint1[`T86_H_STATE_LSB +: 4];
  assign h1_wr    = hint1[`T86_H_WR_BIT];
  assign h1_addr  = hint1[`T86_H_ADDR_LSB +: `T86_WORD];
  assign h1_data  = hint1[`T86_H_DATA_LSB +: `T86_WORD];
  assign h2_wr    = hint2[`T86_H_WR_BIT];
  assign h2_addr  = hint2[`T86_H_ADDR_LSB +: `T86_WORD];

  assign src_reg = regs[src_sel];
  assign dst_reg = regs[dec.dest_sel];

  // Unknown opcode bytes become OPC_ILLEGAL.
  always_comb begin
    case (opc_byte)
      OPC_MOV, OPC_ADD, OPC_SUB, OPC_AND, OPC_XOR,
      OPC_INC, OPC_JZ, OPC_LOOP, OPC_INT80: dec.opc = t86_opc_e'(opc_byte);
      default: dec.opc = OPC_ILLEGAL;
    endcase
  end

  assign dec.mem_addr = (dec.dest_kind == KIND_MEM) ? dst_reg + imm_ext : src_reg + imm_ext;

  always_comb begin
    case (src_kind)
      KIND_REG: dec.src_val = src_reg;
      KIND_IMM: dec.src_val = imm_ext;
      KIND_MEM: dec.src_val = h1_data;
      default:  dec.src_val = '0;
    endcase
    // int 0x80 takes the syscall state nibble as its operand.
    if (dec.opc == OPC_INT80) begin
      dec.src_val = {{(`T86_WORD-4){1'b0}}, h1_state};
    end
  end

  // A memory destination reads its old value from hint1.
  always_comb begin
    case (dec.dest_kind)
      KIND_REG: dec.dst_val = dst_reg;
      KIND_MEM: dec.dst_val = h1_data;
      default:  dec.dst_val = '0;
    endcase
  end

  assign mem_rd = (src_kind == KIND_MEM) || (dec.dest_kind == KIND_MEM && dec.opc != OPC_MOV);

  assign dec.hint_fault =
      (mem_rd && (h1_addr != dec.mem_addr || h1_wr)) ||
      (dec.dest_kind == KIND_MEM && h2_wr && h2_addr != dec.mem_addr) ||
      (dec.opc == OPC_INT80 && h1_state == SYS_WRITE && h1_addr != regs[REG_ECX]);

  // Only hint1 serves reads, so a step never has two memory operands.
  a_no_mem_to_mem: assert property (@(posedge dec.i_clk)
    !(src_kind == KIND_MEM && dec.dest_kind == KIND_MEM));

endmodule

`default_nettype wire

// ==== hw/alu_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

module alu_execute (
  t86_decoded_if.exec            dec,
  input  wire t86_pkg::t86_regs_t i_regs,
  input  wire [`T86_WORD-1:0]    i_eip,
  input  wire [`T86_WORD-1:0]    i_eflags,
  output logic [`T86_WORD-1:0]   o_result,
  output logic [`T86_WORD-1:0]   o_next_eflags,
  output logic [`T86_WORD-1:0]   o_next_eip,
  output logic [`T86_WORD-1:0]   o_ecx_next
);
  import t86_pkg::*;

  logic                 carry;
  logic                 flags_upd;
  logic                 taken;
  logic [`T86_WORD-1:0] len_ext;

  assign o_ecx_next = i_regs[REG_ECX] - 1'b1;
  assign len_ext    = {{(`T86_WORD-`T86_I_LEN_W){1'b0}}, dec.instr_len};

  always_comb begin
    carry     = i_eflags[`T86_CF];
    flags_upd = 1'b1;
    case (dec.opc)
      OPC_ADD: {carry, o_result} = {1'b0, dec.dst_val} + {1'b0, dec.src_val};
      // Top bit of the widened difference is the borrow.
      OPC_SUB: {carry, o_result} = {1'b0, dec.dst_val} - {1'b0, dec.src_val};
      OPC_AND: begin
        o_result = dec.dst_val & dec.src_val;
        carry    = 1'b0;
      end
      OPC_XOR: begin
        o_result = dec.dst_val ^ dec.src_val;
        carry    = 1'b0;
      end
      OPC_INC: o_result = dec.dst_val + 1'b1;
      OPC_MOV: begin
        o_result  = dec.src_val;
        flags_upd = 1'b0;
      end
      default: begin
        o_result  = dec.dst_val;
        flags_upd = 1'b0;
      end
    endcase
  end

  always_comb begin
    o_next_eflags = i_eflags;
    if (flags_upd) begin
      o_next_eflags[`T86_CF] = carry;
      o_next_eflags[`T86_ZF] = (o_result == '0);
      o_next_eflags[`T86_SF] = o_result[`T86_WORD-1];
    end
  end

  // Branch displacement comes in as the immediate source.
  always_comb begin
    case (dec.opc)
      OPC_JZ:   taken = i_eflags[`T86_ZF];
      OPC_LOOP: taken = (o_ecx_next != '0);
      default:  taken = 1'b0;
    endcase
  end

  assign o_next_eip = i_eip + len_ext + (taken ? dec.src_val : '0);

  // A carry out of ADD leaves the sum below the first operand.
  a_add_carry: assert property (@(posedge dec.i_clk)
    dec.opc == OPC_ADD |-> o_next_eflags[`T86_CF] == (o_result < dec.dst_val));

  // SUB borrows exactly when the subtrahend is the larger one.
  a_sub_borrow: assert property (@(posedge dec.i_clk)
    dec.opc == OPC_SUB |-> o_next_eflags[`T86_CF] == (dec.dst_val < dec.src_val));

endmodule

`default_nettype wire

// ==== hw/syscall_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

module syscall_unit (
  t86_decoded_if.exec             dec,
  input  wire t86_pkg::t86_regs_t i_regs,
  input  wire [`T86_WORD-1:0]     i_hint_data,
  output t86_pkg::t86_sys_e       o_sys_state,
  output logic [`T86_WORD-1:0]    o_eax,
  output logic [`T86_WORD-1:0]    o_ecx,
  output logic [`T86_WORD-1:0]    o_edx,
  output logic                    o_mem_wr,
  output logic [`T86_WORD-1:0]    o_mem_addr,
  output logic [`T86_WORD-1:0]    o_mem_data
);
  import t86_pkg::*;

  logic is_int80;

  assign is_int80    = (dec.opc == OPC_INT80);
  assign o_sys_state = is_int80 ? t86_sys_e'(dec.src_val[3:0]) : SYS_DONE;

  // read() stores the transferred word at the buffer pointer.
  assign o_mem_addr = i_regs[REG_ECX];
  assign o_mem_data = i_hint_data;

  always_comb begin
    o_eax    = i_regs[REG_EAX];
    o_ecx    = i_regs[REG_ECX];
    o_edx    = i_regs[REG_EDX];
    o_mem_wr = 1'b0;
    case (o_sys_state)
      SYS_DONE: begin
        // Return value of the finished call.
        if (is_int80) begin
          o_eax = i_hint_data;
        end
      end
      SYS_READ: begin
        o_mem_wr = 1'b1;
        o_ecx    = i_regs[REG_ECX] + 32'd4;
        o_edx    = i_regs[REG_EDX] - 32'd4;
      end
      SYS_WRITE: begin
        o_ecx = i_regs[REG_ECX] + 32'd4;
        o_edx = i_regs[REG_EDX] - 32'd4;
      end
      default: ;
    endcase
  end

  a_state_legal: assert property (@(posedge dec.i_clk)
    is_int80 |-> dec.src_val[3:0] inside {SYS_DONE, SYS_READ, SYS_WRITE});

endmodule

`default_nettype wire

// ==== hw/writeback_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

module writeback_regfile (
  input  wire                     i_clk,
  input  wire                     i_rst_n,
  input  wire                     i_step_valid,
  t86_decoded_if.wb               dec,
  input  wire [`T86_WORD-1:0]     i_result,
  input  wire [`T86_WORD-1:0]     i_next_eflags,
  input  wire [`T86_WORD-1:0]     i_next_eip,
  input  wire [`T86_WORD-1:0]     i_ecx_next,
  input  wire t86_pkg::t86_sys_e  i_sys_state,
  input  wire [`T86_WORD-1:0]     i_sys_eax,
  input  wire [`T86_WORD-1:0]     i_sys_ecx,
  input  wire [`T86_WORD-1:0]     i_sys_edx,
  input  wire                     i_sys_mem_wr,
  input  wire [`T86_WORD-1:0]     i_sys_mem_addr,
  input  wire [`T86_WORD-1:0]     i_sys_mem_data,
  input  wire t86_pkg::t86_regs_t i_regs,
  input  wire [`T86_WORD-1:0]     i_eip,
  input  wire [`T86_WORD-1:0]     i_eflags,
  output logic                    o_valid,
  output t86_pkg::t86_regs_t      o_regs,
  output logic [`T86_WORD-1:0]    o_eip,
  output logic [`T86_WORD-1:0]    o_eflags,
  output t86_pkg::t86_sys_e       o_sys_state,
  output logic                    o_mem_wr,
  output logic [`T86_WORD-1:0]    o_mem_addr,
  output logic [`T86_WORD-1:0]    o_mem_data,
  output logic                    o_hint_fault
);
  import t86_pkg::*;

  logic                 is_int80;
  logic                 alu_writes;
  logic                 alu_mem_wr;
  t86_regs_t            nxt_regs;
  logic [`T86_WORD-1:0] nxt_eip;
  logic [`T86_WORD-1:0] nxt_eflags;
  logic                 nxt_mem_wr;
  logic [`T86_WORD-1:0] nxt_mem_addr;
  logic [`T86_WORD-1:0] nxt_mem_data;

  assign is_int80   = (dec.opc == OPC_INT80);
  // Opcodes that produce a value for their destination.
  assign alu_writes = dec.opc inside {OPC_MOV, OPC_ADD, OPC_SUB, OPC_AND, OPC_XOR, OPC_INC};
  assign alu_mem_wr = alu_writes && (dec.dest_kind == KIND_MEM);

  always_comb begin
    nxt_regs     = i_regs;
    nxt_eip      = i_next_eip;
    nxt_eflags   = i_next_eflags;
    nxt_mem_wr   = alu_mem_wr;
    nxt_mem_addr = dec.mem_addr;
    nxt_mem_data = i_result;
    if (is_int80) begin
      nxt_regs[REG_EAX] = i_sys_eax;
      nxt_regs[REG_ECX] = i_sys_ecx;
      nxt_regs[REG_EDX] = i_sys_edx;
      nxt_eflags        = i_eflags;
      // The int 0x80 step repeats until the call is done.
      if (i_sys_state != SYS_DONE) begin
        nxt_eip = i_eip;
      end
      nxt_mem_wr   = i_sys_mem_wr;
      nxt_mem_addr = i_sys_mem_addr;
      nxt_mem_data = i_sys_mem_data;
    end else begin
      if (alu_writes && dec.dest_kind == KIND_REG) begin
        nxt_regs[dec.dest_sel] = i_result;
      end
      if (dec.opc == OPC_LOOP) begin
        nxt_regs[REG_ECX] = i_ecx_next;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid      <= 1'b0;
      o_mem_wr     <= 1'b0;
      o_hint_fault <= 1'b0;
      o_regs       <= '0;
      o_eip        <= '0;
      o_eflags     <= '0;
      o_sys_state  <= SYS_DONE;
    end else begin
      o_valid      <= i_step_valid;
      o_mem_wr     <= i_step_valid && nxt_mem_wr;
      o_hint_fault <= i_step_valid && dec.hint_fault;
      if (i_step_valid) begin
        o_regs      <= nxt_regs;
        o_eip       <= nxt_eip;
        o_eflags    <= nxt_eflags;
        o_sys_state <= i_sys_state;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step_valid) begin
      o_mem_addr <= nxt_mem_addr;
      o_mem_data <= nxt_mem_data;
    end
  end

  a_one_mem_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_step_valid |-> !(alu_mem_wr && i_sys_mem_wr));

endmodule

`default_nettype wire

// ==== hw/tiny86_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

module tiny86_top (
  input  wire                             i_clk,
  input  wire                             i_rst_n,
  input  wire                             i_step_valid,
  input  wire [`T86_STEP_W-1:0]           i_step,
  output wire                             o_valid,
  output wire [`T86_NREGS*`T86_WORD-1:0]  o_regs,
  output wire [`T86_WORD-1:0]             o_eip,
  output wire [`T86_WORD-1:0]             o_eflags,
  output wire [3:0]                       o_sys_state,
  output wire                             o_mem_wr,
  output wire [`T86_WORD-1:0]             o_mem_addr,
  output wire [`T86_WORD-1:0]             o_mem_data,
  output wire                             o_hint_fault
);
  import t86_pkg::*;

  t86_regs_t            regs;
  logic [`T86_WORD-1:0] eip;
  logic [`T86_WORD-1:0] eflags;
  logic [`T86_WORD-1:0] alu_result;
  logic [`T86_WORD-1:0] alu_eflags;
  logic [`T86_WORD-1:0] alu_eip;
  logic [`T86_WORD-1:0] alu_ecx;
  t86_sys_e             sys_state;
  logic [`T86_WORD-1:0] sys_eax;
  logic [`T86_WORD-1:0] sys_ecx;
  logic [`T86_WORD-1:0] sys_edx;
  logic                 sys_mem_wr;
  logic [`T86_WORD-1:0] sys_mem_addr;
  logic [`T86_WORD-1:0] sys_mem_data;

  t86_decoded_if dec_if (.i_clk(i_clk));

  step_decode u_decode (
    .i_step   (i_step),
    .dec      (dec_if.decode),
    .o_regs   (regs),
    .o_eip    (eip),
    .o_eflags (eflags)
  );

  // Execute and syscall units work side by side on the same decoded step.
  alu_execute u_alu (
    .dec           (dec_if.exec),
    .i_regs        (regs),
    .i_eip         (eip),
    .i_eflags      (eflags),
    .o_result      (alu_result),
    .o_next_eflags (alu_eflags),
    .o_next_eip    (alu_eip),
    .o_ecx_next    (alu_ecx)
  );

  syscall_unit u_syscall (
    .dec         (dec_if.exec),
    .i_regs      (regs),
    .i_hint_data (i_step[`T86_HINT2_LSB + `T86_H_DATA_LSB +: `T86_WORD]),
    .o_sys_state (sys_state),
    .o_eax       (sys_eax),
    .o_ecx       (sys_ecx),
    .o_edx       (sys_edx),
    .o_mem_wr    (sys_mem_wr),
    .o_mem_addr  (sys_mem_addr),
    .o_mem_data  (sys_mem_data)
  );

  writeback_regfile u_wb (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_step_valid   (i_step_valid),
    .dec            (dec_if.wb),
    .i_result       (alu_result),
    .i_next_eflags  (alu_eflags),
    .i_next_eip     (alu_eip),
    .i_ecx_next     (alu_ecx),
    .i_sys_state    (sys_state),
    .i_sys_eax      (sys_eax),
    .i_sys_ecx      (sys_ecx),
    .i_sys_edx      (sys_edx),
    .i_sys_mem_wr   (sys_mem_wr),
    .i_sys_mem_addr (sys_mem_addr),
    .i_sys_mem_data (sys_mem_data),
    .i_regs         (regs),
    .i_eip          (eip),
    .i_eflags       (eflags),
    .o_valid        (o_valid),
    .o_regs         (o_regs),
    .o_eip          (o_eip),
    .o_eflags       (o_eflags),
    .o_sys_state    (o_sys_state),
    .o_mem_wr       (o_mem_wr),
    .o_mem_addr     (o_mem_addr),
    .o_mem_data     (o_mem_data),
    .o_hint_fault   (o_hint_fault)
  );

endmodule

`default_nettype wire

// ==== sim/tb_tiny86.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "t86_settings.svh"

module tb_tiny86;
  import t86_pkg::*;

  localparam int          RST_CYCLES = 10;
  localparam int          MAX_TESTS  = 32;
  localparam logic [31:0] EIP0       = 32'h0000_1000;
  localparam logic [31:0] ECX0       = 32'h0000_0011;
  localparam logic [31:0] EDX0       = 32'h0000_0022;
  localparam logic [71:0] NO_HINT    = '0;
  localparam logic [31:0] FLAG_MASK  = (1 << `T86_CF) | (1 << `T86_ZF) | (1 << `T86_SF);

  logic                               clk;
  logic                               i_rst_n;
  logic                               i_step_valid;
  logic [`T86_STEP_W-1:0]             i_step;
  wire                                o_valid;
  wire  [`T86_NREGS*`T86_WORD-1:0]    o_regs;
  wire  [`T86_WORD-1:0]               o_eip;
  wire  [`T86_WORD-1:0]               o_eflags;
  wire  [3:0]                         o_sys_state;
  wire                                o_mem_wr;
  wire  [`T86_WORD-1:0]               o_mem_addr;
  wire  [`T86_WORD-1:0]               o_mem_data;
  wire                                o_hint_fault;

  // Stimulus and expected results, one row per step.
  string                              t_name     [0:MAX_TESTS-1];
  logic [`T86_STEP_W-1:0]             t_step     [0:MAX_TESTS-1];
  logic [`T86_NREGS*`T86_WORD-1:0]    x_regs     [0:MAX_TESTS-1];
  logic [31:0]                        x_eip      [0:MAX_TESTS-1];
  logic [31:0]                        x_eflags   [0:MAX_TESTS-1];
  logic [3:0]                         x_sys      [0:MAX_TESTS-1];
  logic                               x_mem_wr   [0:MAX_TESTS-1];
  logic [31:0]                        x_mem_addr [0:MAX_TESTS-1];
  logic [31:0]                        x_mem_data [0:MAX_TESTS-1];
  logic                               x_fault    [0:MAX_TESTS-1];

  integer seed;
  int     n_tests     = 0;
  int     errors      = 0;
  int     valid_seen  = 0;
  int     cycles      = 0;
  int     cycle_limit = 0;
  int     cur_idx     = 0;
  int     sent_idx    = 0;
  logic   sent_valid  = 1'b0;

  tiny86_top UUT (
    .i_clk        (clk),
    .i_rst_n      (i_rst_n),
    .i_step_valid (i_step_valid),
    .i_step       (i_step),
    .o_valid      (o_valid),
    .o_regs       (o_regs),
    .o_eip        (o_eip),
    .o_eflags     (o_eflags),
    .o_sys_state  (o_sys_state),
    .o_mem_wr     (o_mem_wr),
    .o_mem_addr   (o_mem_addr),
    .o_mem_data   (o_mem_data),
    .o_hint_fault (o_hint_fault)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [47:0] encode_instr(input logic [7:0] opc, input logic [1:0] dk,
      input logic [2:0] ds, input logic [1:0] sk, input logic [2:0] ss,
      input logic [3:0] len, input logic [25:0] imm);
    return {imm, len, ss, sk, ds, dk, opc};
  endfunction

  function automatic logic [71:0] encode_hint(input logic [3:0] state, input logic wr,
      input logic [31:0] addr, input logic [31:0] data);
    return {data, addr, 3'b000, wr, state};
  endfunction

  // Flag triple is {SF, ZF, CF}.
  function automatic logic [31:0] with_flags(input logic [31:0] base, input logic [2:0] fl);
    logic [31:0] w;
    w = base;
    w[`T86_CF] = fl[0];
    w[`T86_ZF] = fl[1];
    w[`T86_SF] = fl[2];
    return w;
  endfunction

  // Registers esp..edi and the other eflags bits get random values that must pass through.
  task automatic add_test(
    input string       name,
    input logic [31:0] eax, ecx, edx, ebx,
    input logic [2:0]  fl,
    input logic [47:0] instr,
    input logic [71:0] hint1, hint2,
    input logic [31:0] e_eax, e_ecx, e_edx, e_eip,
    input logic [2:0]  e_fl,
    input logic        e_mw,
    input logic [31:0] e_maddr, e_mdata,
    input logic        e_fault
  );
    logic [127:0] upper;
    logic [31:0]  base_flags;
    upper      = {$random(seed), $random(seed), $random(seed), $random(seed)};
    base_flags = $random(seed) & ~FLAG_MASK;
    t_name[n_tests]     = name;
    t_step[n_tests]     = {hint2, hint1, instr, with_flags(base_flags, fl), EIP0,
                           upper, ebx, edx, ecx, eax};
    x_regs[n_tests]     = {upper, ebx, e_edx, e_ecx, e_eax};
    x_eip[n_tests]      = e_eip;
    x_eflags[n_tests]   = with_flags(base_flags, e_fl);
    x_sys[n_tests]      = (instr[7:0] == OPC_INT80) ? hint1[3:0] : 4'd0;
    x_mem_wr[n_tests]   = e_mw;
    x_mem_addr[n_tests] = e_maddr;
    x_mem_data[n_tests] = e_mdata;
    x_fault[n_tests]    = e_fault;
    n_tests++;
  endtask

  task automatic build_table;
    add_test("add_reg", 32'd5, ECX0, EDX0, 32'd7, 3'b000,
             encode_instr(OPC_ADD, KIND_REG, 0, KIND_REG, 3, 2, 0), NO_HINT, NO_HINT,
             32'd12, ECX0, EDX0, EIP0 + 2, 3'b000, 1'b0, 0, 0, 1'b0);
    add_test("add_carry", 32'hffff_ffff, ECX0, EDX0, 32'd1, 3'b000,
             encode_instr(OPC_ADD, KIND_REG, 0, KIND_REG, 3, 2, 0), NO_HINT, NO_HINT,
             32'd0, ECX0, EDX0, EIP0 + 2, 3'b011, 1'b0, 0, 0, 1'b0);
    add_test("sub_borrow", 32'd3, ECX0, EDX0, 32'd5, 3'b000,
             encode_instr(OPC_SUB, KIND_REG, 0, KIND_REG, 3, 2, 0), NO_HINT, NO_HINT,
             32'hffff_fffe, ECX0, EDX0, EIP0 + 2, 3'b101, 1'b0, 0, 0, 1'b0);
    add_test("sub_zero", 32'd9, ECX0, EDX0, 32'd9, 3'b001,
             encode_instr(OPC_SUB, KIND_REG, 0, KIND_REG, 3, 2, 0), NO_HINT, NO_HINT,
             32'd0, ECX0, EDX0, EIP0 + 2, 3'b010, 1'b0, 0, 0, 1'b0);
    add_test("and_reg", 32'hf0f0_00ff, ECX0, EDX0, 32'h8000_00f0, 3'b001,
             encode_instr(OPC_AND, KIND_REG, 0, KIND_REG, 3, 2, 0), NO_HINT, NO_HINT,
             32'h8000_00f0, ECX0, EDX0, EIP0 + 2, 3'b100, 1'b0, 0, 0, 1'b0);
    add_test("xor_reg", 32'h1234_5678, ECX0, EDX0, 32'h1234_5678, 3'b101,
             encode_instr(OPC_XOR, KIND_REG, 0, KIND_REG, 3, 2, 0), NO_HINT, NO_HINT,
             32'd0, ECX0, EDX0, EIP0 + 2, 3'b010, 1'b0, 0, 0, 1'b0);
    // INC keeps CF both when set and when clear.
    add_test("inc_keep_cf", 32'hffff_ffff, ECX0, EDX0, 32'd0, 3'b001,
             encode_instr(OPC_INC, KIND_REG, 0, KIND_NONE, 0, 1, 0), NO_HINT, NO_HINT,
             32'd0, ECX0, EDX0, EIP0 + 1, 3'b011, 1'b0, 0, 0, 1'b0);
    add_test("inc_cf_clear", 32'h7fff_ffff, ECX0, EDX0, 32'd0, 3'b000,
             encode_instr(OPC_INC, KIND_REG, 0, KIND_NONE, 0, 1, 0), NO_HINT, NO_HINT,
             32'h8000_0000, ECX0, EDX0, EIP0 + 1, 3'b100, 1'b0, 0, 0, 1'b0);
    add_test("mov_mem_load", 32'd1, ECX0, EDX0, 32'h2000, 3'b010,
             encode_instr(OPC_MOV, KIND_REG, 0, KIND_MEM, 3, 3, 8),
             encode_hint(0, 0, 32'h2008, 32'hcafe_babe), NO_HINT,
             32'hcafe_babe, ECX0, EDX0, EIP0 + 3, 3'b010, 1'b0, 0, 0, 1'b0);
    add_test("mov_mem_fault", 32'd1, ECX0, EDX0, 32'h2000, 3'b010,
             encode_instr(OPC_MOV, KIND_REG, 0, KIND_MEM, 3, 3, 8),
             encode_hint(0, 0, 32'h200c, 32'hcafe_babe), NO_HINT,
             32'hcafe_babe, ECX0, EDX0, EIP0 + 3, 3'b010, 1'b0, 0, 0, 1'b1);
    // Old memory value comes from hint1, the store is echoed in hint2.
    add_test("add_mem_dest", 32'h22, ECX0, EDX0, 32'h3000, 3'b000,
             encode_instr(OPC_ADD, KIND_MEM, 3, KIND_REG, 0, 3, 4),
             encode_hint(0, 0, 32'h3004, 32'h10), encode_hint(0, 1, 32'h3004, 32'h32),
             32'h22, ECX0, EDX0, EIP0 + 3, 3'b000, 1'b1, 32'h3004, 32'h32, 1'b0);
    add_test("jz_taken", 32'd0, ECX0, EDX0, 32'd0, 3'b010,
             encode_instr(OPC_JZ, KIND_NONE, 0, KIND_IMM, 0, 2, 26'h10), NO_HINT, NO_HINT,
             32'd0, ECX0, EDX0, EIP0 + 32'h12, 3'b010, 1'b0, 0, 0, 1'b0);
    add_test("jz_not_taken", 32'd0, ECX0, EDX0, 32'd0, 3'b000,
             encode_instr(OPC_JZ, KIND_NONE, 0, KIND_IMM, 0, 2, 26'h10), NO_HINT, NO_HINT,
             32'd0, ECX0, EDX0, EIP0 + 2, 3'b000, 1'b0, 0, 0, 1'b0);
    add_test("loop_taken", 32'd0, 32'd3, EDX0, 32'd0, 3'b100,
             encode_instr(OPC_LOOP, KIND_NONE, 0, KIND_IMM, 0, 2, 26'h3ff_fffa),
             NO_HINT, NO_HINT,
             32'd0, 32'd2, EDX0, EIP0 + 2 - 6, 3'b100, 1'b0, 0, 0, 1'b0);
    add_test("loop_exit", 32'd0, 32'd1, EDX0, 32'd0, 3'b000,
             encode_instr(OPC_LOOP, KIND_NONE, 0, KIND_IMM, 0, 2, 26'h3ff_fffa),
             NO_HINT, NO_HINT,
             32'd0, 32'd0, EDX0, EIP0 + 2, 3'b000, 1'b0, 0, 0, 1'b0);
    add_test("int80_read", 32'd3, 32'h4000, 32'h10, 32'd0, 3'b001,
             encode_instr(OPC_INT80, KIND_NONE, 0, KIND_NONE, 0, 2, 0),
             encode_hint(SYS_READ, 0, 0, 0), encode_hint(0, 0, 0, 32'hdead_beef),
             32'd3, 32'h4004, 32'hc, EIP0, 3'b001, 1'b1, 32'h4000, 32'hdead_beef, 1'b0);
    add_test("int80_write", 32'd4, 32'h5000, 32'h8, 32'd0, 3'b000,
             encode_instr(OPC_INT80, KIND_NONE, 0, KIND_NONE, 0, 2, 0),
             encode_hint(SYS_WRITE, 0, 32'h5000, 0), NO_HINT,
             32'd4, 32'h5004, 32'h4, EIP0, 3'b000, 1'b0, 0, 0, 1'b0);
    add_test("int80_done", 32'd3, ECX0, EDX0, 32'd0, 3'b010,
             encode_instr(OPC_INT80, KIND_NONE, 0, KIND_NONE, 0, 2, 0),
             encode_hint(SYS_DONE, 0, 0, 0), encode_hint(0, 0, 0, 32'h20),
             32'h20, ECX0, EDX0, EIP0 + 2, 3'b010, 1'b0, 0, 0, 1'b0);
  endtask

  task automatic check_field(input string test, input string field,
      input logic [255:0] exp, input logic [255:0] act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %0h, actual %0h", test, field, exp, act);
      errors++;
    end
  endtask

  task automatic check_outputs(input int idx);
    check_field(t_name[idx], "eax", x_regs[idx][31:0], o_regs[31:0]);
    check_field(t_name[idx], "ecx", x_regs[idx][63:32], o_regs[63:32]);
    check_field(t_name[idx], "edx", x_regs[idx][95:64], o_regs[95:64]);
    check_field(t_name[idx], "ebx..edi", x_regs[idx][255:96], o_regs[255:96]);
    check_field(t_name[idx], "eip", x_eip[idx], o_eip);
    check_field(t_name[idx], "eflags", x_eflags[idx], o_eflags);
    check_field(t_name[idx], "sys_state", x_sys[idx], o_sys_state);
    check_field(t_name[idx], "mem_wr", x_mem_wr[idx], o_mem_wr);
    check_field(t_name[idx], "hint_fault", x_fault[idx], o_hint_fault);
    if (x_mem_wr[idx]) begin
      check_field(t_name[idx], "mem_addr", x_mem_addr[idx], o_mem_addr);
      check_field(t_name[idx], "mem_data", x_mem_data[idx], o_mem_data);
    end
  endtask

  // Outputs are compared on the falling edge, one cycle after the step was sampled.
  always @(negedge clk) begin
    if (i_rst_n) begin
      if (o_valid !== sent_valid) begin
        $display("Fail o_valid timing: expected %b, actual %b", sent_valid, o_valid);
        errors++;
      end
      if (o_valid === 1'b1 && sent_valid) begin
        valid_seen++;
        check_outputs(sent_idx);
      end
      sent_valid = i_step_valid;
      sent_idx   = cur_idx;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    seed         = 32'h787dad3d;
    i_rst_n      = 1'b0;
    i_step_valid = 1'b0;
    i_step       = '0;
    build_table();
    cycle_limit = n_tests + RST_CYCLES + 20;

    repeat (RST_CYCLES) @(posedge clk);
    i_rst_n <= 1'b1;
    @(negedge clk);
    if (o_valid !== 1'b0 || o_mem_wr !== 1'b0 || o_hint_fault !== 1'b0) begin
      $display("Control outputs were not low after reset");
      errors++;
    end
    if (o_regs !== '0 || o_eip !== '0 || o_eflags !== '0) begin
      $display("Registered state was not zero after reset");
      errors++;
    end

    // Steps go in back to back, one per cycle.
    for (int i = 0; i < n_tests; i++) begin
      @(posedge clk);
      i_step       <= t_step[i];
      i_step_valid <= 1'b1;
      cur_idx      <= i;
    end
    @(posedge clk);
    i_step_valid <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);

    if (valid_seen != n_tests) begin
      $display("Expected %0d output steps but saw %0d", n_tests, valid_seen);
      errors++;
    end
    $display("Steps checked: %0d of %0d, errors: %0d", valid_seen, n_tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hw/t86_pkg.sv
hw/t86_decoded_if.sv
hw/step_decode.sv
hw/alu_execute.sv
hw/syscall_unit.sv
hw/writeback_regfile.sv
hw/tiny86_top.sv
sim/tb_tiny86.sv

// ==== Bender.yml ====
package:
  name: tiny86

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/t86_pkg.sv
      - hw/t86_decoded_if.sv
      - hw/step_decode.sv
      - hw/alu_execute.sv
      - hw/syscall_unit.sv
      - hw/writeback_regfile.sv
      - hw/tiny86_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_tiny86.sv
